/* Makefile */
# lint the RTL, build and run the testbench, clean up

TB_TOP = fetch_unit_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f list.f --top-module fetch_unit

sim:
	verilator --binary --timing -j 0 -f list.f --top-module $(TB_TOP) -o sim_$(TB_TOP)
	./obj_dir/sim_$(TB_TOP) | tee sim.log
	grep -q "Test completed successfully" sim.log

clean:
	rm -rf obj_dir sim.log

/* list.f */
verilog/rv_isa_pkg.sv
verilog/fetch_pkg.sv
verilog/pc_gen.sv
verilog/instr_mem.sv
verilog/fetch_align.sv
verilog/decompressor.sv
verilog/fetch_unit.sv
testbench/fetch_unit_tb.sv

/* testbench/fetch_unit_tb.sv */
module fetch_unit_tb;
    timeunit 1ns;
    timeprecision 1ns;

    localparam int          imem_words = 256;
    localparam logic [31:0] reset_pc   = 32'h0;

    logic                   clk = 1'b0;
    logic                   reset;
    logic                   stall;
    fetch_pkg::redirect_t   redirect;
    logic                   load_en;
    logic [29:0]            load_addr;
    logic [31:0]            load_data;
    fetch_pkg::fetch_inst_t out;

    int seed;
    int errors;
    int checks;
    // program parcels in memory order and the instructions the core should see
    logic [15:0] prog_half[$];
    logic [31:0] exp_inst[$];
    logic        exp_compr[$];

    fetch_unit #(
        .imem_words (imem_words),
        .reset_pc   (reset_pc)
    ) UUT (
        .clk       (clk),
        .reset     (reset),
        .stall     (stall),
        .redirect  (redirect),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data),
        .out       (out)
    );

    always #20 clk = ~clk;

    // background words are 32-bit encodings that differ in every address bit
    function automatic logic [31:0] fill_word(input int a);
        return {~a[15:0], a[13:0], 2'b11};
    endfunction

    task automatic check_value(input string name, input logic [65:0] actual,
                               input logic [65:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("** Error at %0t: %s is %0h, expected %0h", $time, name, actual, expected);
        end
    endtask

    task automatic timeout_fail(input string what);
        $display("timeout at %0t: %s", $time, what);
        $display("checks: %0d errors: %0d", checks, errors);
        $display("Test failed");
        $finish;
    endtask

    // called on a falling edge, returns on the first falling edge with out.valid high
    task automatic wait_valid();
        int cycles;
        cycles = 0;
        while (!out.valid) begin
            if (cycles == 50) begin
                timeout_fail("no instruction came out of the fetch unit");
            end
            cycles++;
            @(negedge clk);
        end
    endtask

    task automatic fill_memory(input int first, input int last);
        for (int a = first; a < last; a++) begin
            load_en   = 1'b1;
            load_addr = 30'(a);
            load_data = fill_word(a);
            @(negedge clk);
        end
        load_en = 1'b0;
    endtask

    // a target at an odd halfword gets a pad parcel that must never come out
    task automatic begin_program(input logic [31:0] start_pc);
        prog_half.delete();
        exp_inst.delete();
        exp_compr.delete();
        if (start_pc[1]) begin
            prog_half.push_back(16'h0000);
        end
    endtask

    task automatic add_wide(input logic [31:0] inst);
        prog_half.push_back(inst[15:0]);
        prog_half.push_back(inst[31:16]);
        exp_inst.push_back(inst);
        exp_compr.push_back(1'b0);
    endtask

    task automatic add_comp(input logic [15:0] parcel, input logic [31:0] expansion);
        prog_half.push_back(parcel);
        exp_inst.push_back(expansion);
        exp_compr.push_back(1'b1);
    endtask

    // writes the parcels as little-endian words, low parcel first
    task automatic load_program(input logic [31:0] start_pc);
        int n;
        if (prog_half.size() % 2 != 0) begin
            prog_half.push_back(16'h0001);
        end
        n = prog_half.size() / 2;
        for (int i = 0; i < n; i++) begin
            load_en   = 1'b1;
            load_addr = start_pc[31:2] + 30'(i);
            load_data = {prog_half[2*i+1], prog_half[2*i]};
            @(negedge clk);
        end
        load_en = 1'b0;
    endtask

    task automatic redirect_to(input logic [31:0] target);
        redirect.valid  = 1'b1;
        redirect.target = target;
        @(negedge clk);
        redirect.valid  = 1'b0;
    endtask

    // out must not move while stall is high, whatever arrives from memory meanwhile
    task automatic hold_stall(input int cycles);
        fetch_pkg::fetch_inst_t held;
        held  = out;
        stall = 1'b1;
        for (int i = 0; i < cycles; i++) begin
            @(negedge clk);
            check_value("out under stall", 66'(out), 66'(held));
        end
        stall = 1'b0;
    endtask

    // each valid output with stall low is taken at the next rising edge
    task automatic collect(input logic [31:0] start_pc, input int stall_at, input int stall_cycles);
        logic [31:0] pc;
        pc = start_pc;
        for (int k = 0; k < exp_inst.size(); k++) begin
            wait_valid();
            if (k == stall_at) begin
                hold_stall(stall_cycles);
            end
            check_value("out.pc", 66'(out.pc), 66'(pc));
            check_value("out.inst", 66'(out.inst), 66'(exp_inst[k]));
            check_value("out.compr", 66'(out.compr), 66'(exp_compr[k]));
            pc = pc + (exp_compr[k] ? 32'd2 : 32'd4);
            @(negedge clk);
        end
    endtask

    task automatic test_reset_start();
        wait_valid();
        check_value("out.pc", 66'(out.pc), 66'(reset_pc));
        check_value("out.inst", 66'(out.inst), 66'(fill_word(0)));
        check_value("out.compr", 66'(out.compr), 66'(1'b0));
    endtask

    task automatic test_wide_stream();
        begin_program(32'h100);
        for (int i = 0; i < 8; i++) begin
            add_wide($random(seed) | 32'h3);
        end
        load_program(32'h100);
        redirect_to(32'h100);
        collect(32'h100, -1, 0);
    endtask

    // hand expansions follow the RV32C tables, c.lwsp is outside the subset
    task automatic test_compressed();
        begin_program(32'h200);
        add_comp(16'h4144, 32'h00452483);
        add_comp(16'hc504, 32'h00952423);
        add_comp(16'h0001, 32'h00000013);
        add_comp(16'h1475, 32'hffd40413);
        add_comp(16'h2801, 32'h010000ef);
        add_comp(16'h98fd, 32'hfff4f493);
        add_comp(16'h810d, 32'h00355513);
        add_comp(16'h8595, 32'h4055d593);
        add_comp(16'hbffd, 32'hfffff06f);
        add_comp(16'hc401, 32'h00040463);
        add_comp(16'hfcf5, 32'hfe049ee3);
        add_comp(16'h029e, 32'h00729293);
        add_comp(16'h8302, 32'h00030067);
        add_comp(16'h9382, 32'h000380e7);
        add_comp(16'h8636, 32'h00d00633);
        add_comp(16'h973e, 32'h00f70733);
        add_comp(16'h4082, 32'h00000000);
        load_program(32'h200);
        redirect_to(32'h200);
        collect(32'h200, -1, 0);
    endtask

    // three of the 32-bit instructions straddle a word boundary
    task automatic test_mixed();
        begin_program(32'h280);
        add_comp(16'h1475, 32'hffd40413);
        add_wide(32'h00c58533);
        add_wide(32'h0080006f);
        add_comp(16'h0001, 32'h00000013);
        add_comp(16'h8636, 32'h00d00633);
        add_wide(32'hfe0f8ee3);
        add_comp(16'hbffd, 32'hfffff06f);
        load_program(32'h280);
        redirect_to(32'h280);
        collect(32'h280, -1, 0);
    endtask

    task automatic test_stall();
        begin_program(32'h300);
        add_wide($random(seed) | 32'h3);
        add_comp(16'h029e, 32'h00729293);
        add_wide($random(seed) | 32'h3);
        add_wide($random(seed) | 32'h3);
        add_comp(16'h973e, 32'h00f70733);
        add_comp(16'h810d, 32'h00355513);
        add_wide($random(seed) | 32'h3);
        load_program(32'h300);
        redirect_to(32'h300);
        collect(32'h300, 3, 6);
    endtask

    // the second redirect follows the first one directly
    // so the word read for the first target is still in flight and has to be dropped
    task automatic test_redirect_odd();
        begin_program(32'h382);
        add_wide(32'h00c58533);
        add_comp(16'hc401, 32'h00040463);
        add_wide($random(seed) | 32'h3);
        add_comp(16'h8302, 32'h00030067);
        load_program(32'h382);
        redirect_to(32'h100);
        redirect_to(32'h382);
        collect(32'h382, -1, 0);
    endtask

    initial begin
        seed      = 32'hb4da85ce;
        errors    = 0;
        checks    = 0;
        reset     = 1'b1;
        stall     = 1'b0;
        redirect  = '0;
        load_en   = 1'b0;
        load_addr = '0;
        load_data = '0;
        // the first words are written while reset holds the output idle
        fork
            fill_memory(0, 16);
            for (int i = 0; i < 16; i++) begin
                @(negedge clk);
                check_value("out.valid", 66'(out.valid), 66'(1'b0));
            end
        join
        reset = 1'b0;
        // the rest of memory stays ahead of the free-running fetch
        fork
            fill_memory(16, imem_words);
            test_reset_start();
        join
        test_wide_stream();
        test_compressed();
        test_mixed();
        test_stall();
        test_redirect_odd();
        $display("checks: %0d errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* verilog/decompressor.sv */
module decompressor (
    input  rv_isa_pkg::inst_t raw_inst,
    output rv_isa_pkg::inst_t inst,
    output logic              compr
);

    // the aligner always places the instruction in the low bits
    rv_isa_pkg::half_t h;
    // full register fields of the CI and CR formats
    // h[6:2] doubles as the low five immediate bits in CI
    logic [4:0] rd;
    logic [4:0] rs2;
    // x8 to x15 register fields of the CL, CS, CB and CA formats
    // c.lw puts its destination in the rs2' position
    logic [4:0] rs1_p;
    logic [4:0] rs2_p;
    // jal immediate field shared by c.jal and c.j
    logic [19:0] j_imm;
    // branch immediate split around rs2 and rs1, shared by c.beqz and c.bnez
    logic [6:0]  b_imm_hi;
    logic [4:0]  b_imm_lo;

    assign h     = raw_inst[15:0];
    assign rd    = h[11:7];
    assign rs2   = h[6:2];
    assign rs1_p = {2'b01, h[9:7]};
    assign rs2_p = {2'b01, h[4:2]};

    assign j_imm = {h[12], h[8], h[10:9], h[6], h[7], h[2], h[11], h[5:3],
                    h[12], {8{h[12]}}};
    assign b_imm_hi = {{4{h[12]}}, h[6:5], h[2]};
    assign b_imm_lo = {h[11:10], h[4:3], h[12]};

    // the core steps by 2 when this is high
    assign compr = (raw_inst[1:0] != 2'b11);

    always_comb begin
        // unsupported encodings fall through as zero, which the core rejects
        inst = '0;
        if (!compr) begin
            inst = raw_inst;
        end else begin
            case ({h[15:13], h[1:0]})
                // c.lw
                {3'b010, rv_isa_pkg::quad_c0}: begin
                    inst = {5'b00000, h[5], h[12:10], h[6], 2'b00, rs1_p,
                            rv_isa_pkg::f3_word, rs2_p, rv_isa_pkg::op_load};
                end
                // c.sw
                {3'b110, rv_isa_pkg::quad_c0}: begin
                    inst = {5'b00000, h[5], h[12], rs2_p, rs1_p, rv_isa_pkg::f3_word,
                            h[11:10], h[6], 2'b00, rv_isa_pkg::op_store};
                end
                // c.addi, and c.nop comes out of the same form as addi x0, x0, 0
                {3'b000, rv_isa_pkg::quad_c1}: begin
                    inst = {{7{h[12]}}, rs2, rd, rv_isa_pkg::f3_add, rd,
                            rv_isa_pkg::op_op_imm};
                end
                // c.jal links through ra
                {3'b001, rv_isa_pkg::quad_c1}: begin
                    inst = {j_imm, rv_isa_pkg::reg_link, rv_isa_pkg::op_jal};
                end
                // c.andi, c.srli and c.srai share funct3 and split on bits 11:10
                {3'b100, rv_isa_pkg::quad_c1}: begin
                    if (h[11:10] == 2'b10) begin
                        inst = {{7{h[12]}}, rs2, rs1_p, rv_isa_pkg::f3_and, rs1_p,
                                rv_isa_pkg::op_op_imm};
                    end else if (!h[12] && rs2 == 5'd0) begin
                        // a zero shift amount is a hint, left as zero
                        inst = '0;
                    end else if (h[11:10] == 2'b00) begin
                        inst = {7'b0000000, rs2, rs1_p, rv_isa_pkg::f3_sr, rs1_p,
                                rv_isa_pkg::op_op_imm};
                    end else if (h[11:10] == 2'b01) begin
                        inst = {7'b0100000, rs2, rs1_p, rv_isa_pkg::f3_sr, rs1_p,
                                rv_isa_pkg::op_op_imm};
                    end
                    // the register-register forms of this group stay zero
                end
                // c.j is c.jal without the link
                {3'b101, rv_isa_pkg::quad_c1}: begin
                    inst = {j_imm, rv_isa_pkg::reg_zero, rv_isa_pkg::op_jal};
                end
                // c.beqz compares rs1' against x0
                {3'b110, rv_isa_pkg::quad_c1}: begin
                    inst = {b_imm_hi, rv_isa_pkg::reg_zero, rs1_p, rv_isa_pkg::f3_beq,
                            b_imm_lo, rv_isa_pkg::op_branch};
                end
                // c.bnez
                {3'b111, rv_isa_pkg::quad_c1}: begin
                    inst = {b_imm_hi, rv_isa_pkg::reg_zero, rs1_p, rv_isa_pkg::f3_bne,
                            b_imm_lo, rv_isa_pkg::op_branch};
                end
                // c.slli
                {3'b000, rv_isa_pkg::quad_c2}: begin
                    inst = {7'b0000000, rs2, rd, rv_isa_pkg::f3_sll, rd,
                            rv_isa_pkg::op_op_imm};
                end
                // c.jr, c.jalr, c.mv and c.add
                {3'b100, rv_isa_pkg::quad_c2}: begin
                    if (rs2 == rv_isa_pkg::reg_zero) begin
                        // bit 12 picks the linking jump, rs1 = x0 is reserved or ebreak
                        if (rd != rv_isa_pkg::reg_zero) begin
                            inst = {12'h000, rd, 3'b000,
                                    h[12] ? rv_isa_pkg::reg_link : rv_isa_pkg::reg_zero,
                                    rv_isa_pkg::op_jalr};
                        end
                    end else if (rd != rv_isa_pkg::reg_zero) begin
                        // c.mv adds to x0, c.add adds to rd itself
                        inst = {7'b0000000, rs2, h[12] ? rd : rv_isa_pkg::reg_zero,
                                rv_isa_pkg::f3_add, rd, rv_isa_pkg::op_op};
                    end
                end
                default: begin
                    inst = '0;
                end
            endcase
        end
    end

endmodule

/* verilog/fetch_align.sv */
module fetch_align #(
    parameter logic [31:0] reset_pc = 32'h0
) (
    input  logic                   clk,
    input  logic                   reset,
    input  fetch_pkg::redirect_t   redirect,
    input  logic                   stall,
    input  fetch_pkg::fetch_word_t word,
    output logic                   fetch_hold,
    output logic                   raw_valid,
    output logic [31:0]            raw_pc,
    output rv_isa_pkg::inst_t      raw_inst
);

    // parcel queue, entry 0 is the oldest and holds the next instruction start
    rv_isa_pkg::half_t [2:0] parcels;
    rv_isa_pkg::half_t [2:0] parcels_next;
    // number of queued parcels, 0 to 3
    logic [1:0]  cnt;
    logic [1:0]  cnt_next;
    logic [31:0] head_pc;
    // word address the queue expects next
    logic [29:0] exp_word;
    // first word after a redirect to an odd halfword only delivers its upper parcel
    logic        skip;

    logic       head_compr;
    logic       accept;
    logic [1:0] take;
    logic [1:0] keep;
    logic [1:0] in_cnt;

    // anything but 2'b11 in the low bits is a complete 16-bit instruction
    assign head_compr = (parcels[0][1:0] != 2'b11);

    // a 32-bit instruction waits until its second parcel is queued
    assign raw_valid = (cnt != 2'd0) && (head_compr || cnt >= 2'd2);
    assign raw_pc    = head_pc;
    assign raw_inst  = head_compr ? {16'h0000, parcels[0]} : {parcels[1], parcels[0]};

    // stall freezes the head, so the output stays put while it is high
    assign take   = (raw_valid && !stall) ? (head_compr ? 2'd1 : 2'd2) : 2'd0;
    assign keep   = cnt - take;

    // responses from before a redirect carry the wrong address and are dropped
    assign accept = word.valid && (word.addr == {2'b00, exp_word});
    assign in_cnt = accept ? (skip ? 2'd1 : 2'd2) : 2'd0;

    assign cnt_next = keep + in_cnt;

    // with at most one parcel left the next word always fits, even under stall
    assign fetch_hold = (cnt_next >= 2'd2);

    always_comb begin
        parcels_next = parcels;
        // shift out what the decoder took this cycle
        if (take == 2'd1) begin
            parcels_next = {16'h0000, parcels[2:1]};
        end else if (take == 2'd2) begin
            parcels_next = {32'h0000_0000, parcels[2]};
        end
        // then append the new word behind the parcels that remain
        if (accept) begin
            if (skip) begin
                parcels_next[keep] = word.data[31:16];
            end else begin
                parcels_next[keep]        = word.data[15:0];
                parcels_next[keep + 2'd1] = word.data[31:16];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            cnt      <= 2'd0;
            head_pc  <= reset_pc;
            exp_word <= reset_pc[31:2];
            skip     <= reset_pc[1];
        end else if (redirect.valid) begin
            // drop the whole queue and restart at the word holding the target
            cnt      <= 2'd0;
            head_pc  <= redirect.target;
            exp_word <= redirect.target[31:2];
            skip     <= redirect.target[1];
        end else begin
            cnt      <= cnt_next;
            // pc moves by two bytes per parcel taken
            head_pc  <= head_pc + {29'd0, take, 1'b0};
            exp_word <= exp_word + {29'd0, accept};
            if (accept) begin
                skip <= 1'b0;
            end
        end
    end

    // parcel storage only, cnt decides which entries mean anything
    always_ff @(posedge clk) begin
        parcels <= parcels_next;
    end

endmodule

/* verilog/fetch_pkg.sv */
package fetch_pkg;

    // one memory response, tagged with the word address it answers
    typedef struct packed {
        logic        valid;
        logic [31:0] addr;
        logic [31:0] data;
    } fetch_word_t;

    // one instruction handed to the core
    // compr tells the core to step its pc by 2 instead of 4
    typedef struct packed {
        logic              valid;
        logic [31:0]       pc;
        rv_isa_pkg::inst_t inst;
        logic              compr;
    } fetch_inst_t;

    // branch or jump from the core, valid is a single cycle pulse
    // and the target only needs to be halfword aligned
    typedef struct packed {
        logic        valid;
        logic [31:0] target;
    } redirect_t;

endpackage

/* verilog/fetch_unit.sv */
module fetch_unit #(
    parameter int          imem_words = 256,
    parameter logic [31:0] reset_pc   = 32'h0
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   stall,
    input  fetch_pkg::redirect_t   redirect,
    input  logic                   load_en,
    input  logic [29:0]            load_addr,
    input  logic [31:0]            load_data,
    output fetch_pkg::fetch_inst_t out
);

    // address path into the memory
    logic [29:0]            fetch_addr;
    logic                   fetch_en;
    logic                   fetch_hold;
    // tagged response from the memory
    fetch_pkg::fetch_word_t word;
    // aligned candidate and its expansion
    logic                   raw_valid;
    logic [31:0]            raw_pc;
    rv_isa_pkg::inst_t      raw_inst;
    rv_isa_pkg::inst_t      dec_inst;
    logic                   compr;

    pc_gen #(
        .reset_pc (reset_pc)
    ) u_pc_gen (
        .clk        (clk),
        .reset      (reset),
        .redirect   (redirect),
        .fetch_hold (fetch_hold),
        .fetch_addr (fetch_addr),
        .fetch_en   (fetch_en)
    );

    instr_mem #(
        .imem_words (imem_words)
    ) u_instr_mem (
        .clk        (clk),
        .fetch_en   (fetch_en),
        .fetch_addr (fetch_addr),
        .load_en    (load_en),
        .load_addr  (load_addr),
        .load_data  (load_data),
        .word       (word)
    );

    fetch_align #(
        .reset_pc (reset_pc)
    ) u_fetch_align (
        .clk        (clk),
        .reset      (reset),
        .redirect   (redirect),
        .stall      (stall),
        .word       (word),
        .fetch_hold (fetch_hold),
        .raw_valid  (raw_valid),
        .raw_pc     (raw_pc),
        .raw_inst   (raw_inst)
    );

    decompressor u_decompressor (
        .raw_inst (raw_inst),
        .inst     (dec_inst),
        .compr    (compr)
    );

    // the pc and valid come from the aligner, the word and flag from the expander
    assign out.valid = raw_valid;
    assign out.pc    = raw_pc;
    assign out.inst  = dec_inst;
    assign out.compr = compr;

endmodule

/* verilog/instr_mem.sv */
module instr_mem #(
    parameter int imem_words = 256
) (
    input  logic                   clk,
    input  logic                   fetch_en,
    input  logic [29:0]            fetch_addr,
    input  logic                   load_en,
    input  logic [29:0]            load_addr,
    input  logic [31:0]            load_data,
    output fetch_pkg::fetch_word_t word
);

    // only the low word address bits reach the array
    localparam int addr_bits = $clog2(imem_words);

    logic [31:0] mem [imem_words];

    // program load port, one word per cycle
    always_ff @(posedge clk) begin
        if (load_en) begin
            mem[load_addr[addr_bits-1:0]] <= load_data;
        end
    end

    // registered read, the response appears one cycle after fetch_en
    always_ff @(posedge clk) begin
        word.valid <= fetch_en;
        if (fetch_en) begin
            // the address tag lets the aligner spot responses that a redirect made stale
            word.addr <= {2'b00, fetch_addr};
            word.data <= mem[fetch_addr[addr_bits-1:0]];
        end
    end

endmodule

/* verilog/pc_gen.sv */
module pc_gen #(
    parameter logic [31:0] reset_pc = 32'h0
) (
    input  logic                 clk,
    input  logic                 reset,
    input  fetch_pkg::redirect_t redirect,
    input  logic                 fetch_hold,
    output logic [29:0]          fetch_addr,
    output logic                 fetch_en
);

    // set one cycle after reset is released, keeps the memory idle until then
    logic run;

    always_ff @(posedge clk) begin
        if (reset) begin
            fetch_addr <= reset_pc[31:2];
            run        <= 1'b0;
        end else begin
            run <= 1'b1;
            // a redirect wins over hold, the aligner flushes in the same cycle
            if (redirect.valid) begin
                fetch_addr <= redirect.target[31:2];
            end else if (fetch_en) begin
                // the word at fetch_addr is being read now, move on to the next one
                fetch_addr <= fetch_addr + 30'd1;
            end
        end
    end

    // each word is read exactly once and only while the aligner has room for it
    // so a read never has to be repeated or thrown away for lack of space
    assign fetch_en = run && !fetch_hold;

endmodule

/* verilog/rv_isa_pkg.sv */
package rv_isa_pkg;

    // one full RV32I instruction word
    typedef logic [31:0] inst_t;

    // one 16-bit parcel, the unit the fetch stream is cut into
    typedef logic [15:0] half_t;

    // major opcodes that the compressed subset expands into
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_op_imm = 7'b0010011;
    localparam logic [6:0] op_op     = 7'b0110011;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_jalr   = 7'b1100111;
    localparam logic [6:0] op_branch = 7'b1100011;

    // funct3 values of the expanded instructions
    localparam logic [2:0] f3_add  = 3'b000;
    localparam logic [2:0] f3_sll  = 3'b001;
    localparam logic [2:0] f3_sr   = 3'b101;
    localparam logic [2:0] f3_and  = 3'b111;
    // width code shared by lw and sw
    localparam logic [2:0] f3_word = 3'b010;
    localparam logic [2:0] f3_beq  = 3'b000;
    localparam logic [2:0] f3_bne  = 3'b001;

    // low two bits of a compressed parcel select its quadrant
    // and the pattern 2'b11 marks the start of a 32-bit instruction
    localparam logic [1:0] quad_c0 = 2'b00;
    localparam logic [1:0] quad_c1 = 2'b01;
    localparam logic [1:0] quad_c2 = 2'b10;

    // implicit registers of the jump forms
    localparam logic [4:0] reg_zero = 5'd0;
    localparam logic [4:0] reg_link = 5'd1;

endpackage
